/* bm_cfg.svh */
`ifndef BM_CFG_SVH
`define BM_CFG_SVH

// Pixels packed into one memory word
`define BM_PIX_PER_WORD 4

// Frame geometry in pixels
`define BM_THIRD_W      16
`define BM_CENTER_W     24 // Center frame is padded on both sides
`define BM_THIRD_H      8

// Block and search window sizes in pixels
`define BM_BLOCK_W      4  // One memory word wide
`define BM_BLOCK_H      4
`define BM_SEARCH_W     12
`define BM_SEARCH_H     8

`define BM_FIFO_DEPTH   4

// Row widths in words
`define BM_FRAME_WORDS  (`BM_THIRD_W / `BM_PIX_PER_WORD)
`define BM_CENTER_WORDS (`BM_CENTER_W / `BM_PIX_PER_WORD)

// Memory depths hold two halves of one frame each
`define BM_THIRD_DEPTH  (2 * `BM_FRAME_WORDS * `BM_THIRD_H)
`define BM_CENTER_DEPTH (2 * `BM_CENTER_WORDS * `BM_THIRD_H)

`define BM_NUM_CAND     3 // Horizontal candidate positions per block

// The scan counts the real blocks plus the pad blocks on one side
`define BM_BLOCKS_PER_ROW ((`BM_THIRD_W + (`BM_CENTER_W - `BM_THIRD_W) / 2) / `BM_BLOCK_W)
`define BM_BLOCKS_PER_COL (`BM_THIRD_H / `BM_BLOCK_H)

`endif

/* bm_geom_pkg.sv */
`default_nettype none

`include "bm_cfg.svh"

package bm_geom_pkg;

    typedef logic [15:0] word_addr_t; // Wraps on negative offsets

    typedef logic [`BM_PIX_PER_WORD*8-1:0] pixel_word_t;

    typedef logic [5:0] blk_coord_t;

    typedef logic [3:0] img_num_t;

    // Block index as it leaves with a result
    typedef struct packed {
        img_num_t   img;
        blk_coord_t row;
        blk_coord_t col;
    } blk_index_t;

    typedef logic [15:0] sad_t;

    typedef logic [3:0] cand_t;

endpackage

`default_nettype wire

/* bm_job_pkg.sv */
`default_nettype none

package bm_job_pkg;

    import bm_geom_pkg::*;

    // One block to match, as issued by the controller
    typedef struct packed {
        word_addr_t blk_addr;
        word_addr_t srch_addr;
        blk_index_t index;
    } bm_job_t;

    typedef struct packed {
        blk_index_t index;
        cand_t      best_cand; // Word offset inside the window
        sad_t       best_sad;
    } bm_result_t;

    typedef enum logic [1:0] {ST_IDLE, ST_WAITBM, ST_STARTBM, ST_WAIT_FILTER} ctrl_state_t;

    typedef enum logic [1:0] {ENG_IDLE, ENG_READ, ENG_DRAIN, ENG_EMIT} eng_state_t;

endpackage

`default_nettype wire

/* bm_frame_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module bm_frame_ram #(
    parameter int depth = 64
) (
    input  wire                      clk,
    input  wire                      wr_en,
    input  wire bm_geom_pkg::word_addr_t  wr_addr,
    input  wire bm_geom_pkg::pixel_word_t wr_data,
    input  wire bm_geom_pkg::word_addr_t  rd_addr,
    output bm_geom_pkg::pixel_word_t      rd_data
);

    import bm_geom_pkg::*;

    localparam int aw = $clog2(depth);

    pixel_word_t mem [depth];

    always_ff @(posedge clk) begin
        if (wr_en && (wr_addr < depth)) mem[wr_addr[aw-1:0]] <= wr_data;
        // Reads past the end see a zero pixel word
        rd_data <= (rd_addr < depth) ? mem[rd_addr[aw-1:0]] : '0;
    end

endmodule

`default_nettype wire

/* bm_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bm_cfg.svh"

module bm_ctrl_fsm (
    input  wire                      clk,
    input  wire                      reset,
    input  wire bm_geom_pkg::img_num_t img_number_in,
    input  wire                      job_space,
    input  wire bm_geom_pkg::img_num_t done_img,
    output logic                     job_push,
    output bm_job_pkg::bm_job_t      job,
    output logic                     bm_idle,
    output logic                     bm_working_buf
);

    import bm_geom_pkg::*;
    import bm_job_pkg::*;

    localparam int blk_words = `BM_BLOCK_W / `BM_PIX_PER_WORD;

    // Step from one block row to the next
    localparam int third_row_step  = `BM_FRAME_WORDS * `BM_BLOCK_H;
    localparam int center_row_step = `BM_CENTER_WORDS * `BM_BLOCK_H;

    // The window starts above the block by half the height difference
    localparam int srch_rise = `BM_CENTER_WORDS * ((`BM_SEARCH_H - `BM_BLOCK_H) / 2);

    ctrl_state_t state;
    img_num_t    img_number;
    blk_coord_t  blk_col;
    blk_coord_t  blk_row;
    word_addr_t  blk_addr;
    word_addr_t  blk_row_addr; // First block of the next block row
    word_addr_t  srch_addr;
    word_addr_t  srch_row_addr;
    word_addr_t  blk_buf_offset;
    word_addr_t  srch_buf_offset;
    word_addr_t  srch_start;

    assign bm_working_buf = img_number[0];
    assign bm_idle        = (state == ST_IDLE) && job_space;
    assign job_push       = (state == ST_STARTBM); // Space was checked on the way in

    // Odd images live in the upper half of each memory
    assign blk_buf_offset  = img_number[0] ? word_addr_t'(`BM_FRAME_WORDS * `BM_THIRD_H) : '0;
    assign srch_buf_offset = img_number[0] ? word_addr_t'(`BM_CENTER_WORDS * `BM_THIRD_H) : '0;
    assign srch_start      = srch_buf_offset - word_addr_t'(srch_rise);

    always_comb begin
        job.blk_addr  = blk_addr;
        job.srch_addr = srch_addr;
        job.index.img = img_number;
        job.index.row = blk_row;
        job.index.col = blk_col;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            img_number <= '0;
            blk_col    <= '0;
            blk_row    <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if ((img_number_in != img_number) && job_space) begin
                        state         <= ST_STARTBM;
                        blk_col       <= '0;
                        blk_row       <= '0;
                        blk_addr      <= blk_buf_offset;
                        blk_row_addr  <= blk_buf_offset + word_addr_t'(third_row_step);
                        srch_addr     <= srch_start;
                        srch_row_addr <= srch_start + word_addr_t'(center_row_step);
                    end
                end

                ST_WAITBM: begin
                    if (job_space) state <= ST_STARTBM;
                end

                ST_STARTBM: begin
                    if (blk_col == blk_coord_t'(`BM_BLOCKS_PER_ROW - 1)) begin
                        blk_col <= '0;
                        if (blk_row == blk_coord_t'(`BM_BLOCKS_PER_COL - 1)) begin
                            // Last job of the image is out
                            state      <= ST_WAIT_FILTER;
                            img_number <= img_number + 1'b1;
                        end else begin
                            blk_row       <= blk_row + 1'b1;
                            blk_addr      <= blk_row_addr;
                            blk_row_addr  <= blk_row_addr + word_addr_t'(third_row_step);
                            srch_addr     <= srch_row_addr;
                            srch_row_addr <= srch_row_addr + word_addr_t'(center_row_step);
                            state         <= ST_WAITBM;
                        end
                    end else begin
                        blk_col   <= blk_col + 1'b1;
                        blk_addr  <= blk_addr + word_addr_t'(blk_words);
                        srch_addr <= srch_addr + word_addr_t'(blk_words);
                        state     <= ST_WAITBM;
                    end
                end

                ST_WAIT_FILTER: begin
                    // Engine has finished every block of the image
                    if (done_img == img_number) state <= ST_IDLE;
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* bm_job_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bm_cfg.svh"

module bm_job_fifo (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      push,
    input  wire bm_job_pkg::bm_job_t push_data,
    input  wire                      pop,
    output bm_job_pkg::bm_job_t      head,
    output logic                     empty,
    output logic                     space
);

    import bm_job_pkg::*;

    localparam int ptr_w = $clog2(`BM_FIFO_DEPTH);
    localparam int cnt_w = $clog2(`BM_FIFO_DEPTH + 1);

    bm_job_t          mem [`BM_FIFO_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty   = (count == '0);
    assign space   = (count < cnt_w'(`BM_FIFO_DEPTH));
    assign head    = mem[rd_ptr]; // Head shows through without a register
    assign do_push = push && space;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(`BM_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(`BM_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* bm_sad_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bm_cfg.svh"

module bm_sad_engine (
    input  wire                       clk,
    input  wire                       reset,
    input  wire bm_job_pkg::bm_job_t  job_head,
    input  wire                       job_empty,
    output logic                      job_pop,
    output bm_geom_pkg::word_addr_t   blk_rd_addr,
    output bm_geom_pkg::word_addr_t   srch_rd_addr,
    input  wire bm_geom_pkg::pixel_word_t blk_rd_data,
    input  wire bm_geom_pkg::pixel_word_t srch_rd_data,
    output logic                      res_valid,
    output bm_job_pkg::bm_result_t    res,
    output bm_geom_pkg::img_num_t     done_img
);

    import bm_geom_pkg::*;
    import bm_job_pkg::*;

    localparam int row_w         = $clog2(`BM_BLOCK_H);
    localparam int srch_row_skip = (`BM_SEARCH_H - `BM_BLOCK_H) / 2;

    eng_state_t       state;
    bm_job_t          job_q;
    logic [row_w-1:0] row;
    cand_t            cand;
    logic             rd_valid;    // Memory data of the last cycle's read is present
    logic             rd_last_row;
    cand_t            rd_cand;
    sad_t             sad_acc;
    sad_t             row_sad;
    sad_t             cand_sad;
    sad_t             best_sad;
    cand_t            best_cand;

    function automatic sad_t word_sad(input pixel_word_t a, input pixel_word_t b);
        sad_t       sum;
        logic [7:0] pa;
        logic [7:0] pb;
        sum = '0;
        for (int i = 0; i < `BM_PIX_PER_WORD; i++) begin
            pa  = a[i*8 +: 8];
            pb  = b[i*8 +: 8];
            sum = sum + sad_t'((pa > pb) ? (pa - pb) : (pb - pa));
        end
        return sum;
    endfunction

    assign job_pop   = (state == ENG_IDLE) && !job_empty;
    assign res_valid = (state == ENG_EMIT);

    // Window rows start below the job's search address by the vertical margin
    assign blk_rd_addr  = job_q.blk_addr + word_addr_t'(row * `BM_FRAME_WORDS);
    assign srch_rd_addr = job_q.srch_addr + word_addr_t'((row + srch_row_skip) * `BM_CENTER_WORDS)
                          + word_addr_t'(cand);

    assign row_sad  = word_sad(blk_rd_data, srch_rd_data);
    assign cand_sad = sad_acc + row_sad;

    always_comb begin
        res.index     = job_q.index;
        res.best_cand = best_cand;
        res.best_sad  = best_sad;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ENG_IDLE;
            rd_valid <= 1'b0;
            done_img <= '0;
        end else begin
            rd_valid    <= (state == ENG_READ);
            rd_last_row <= (row == row_w'(`BM_BLOCK_H - 1));
            rd_cand     <= cand;

            // Accumulation runs one cycle behind the addresses
            if (rd_valid) begin
                if (rd_last_row) begin
                    sad_acc <= '0;
                    if ((rd_cand == '0) || (cand_sad < best_sad)) begin // Ties keep the lower one
                        best_sad  <= cand_sad;
                        best_cand <= rd_cand;
                    end
                end else begin
                    sad_acc <= cand_sad;
                end
            end

            case (state)
                ENG_IDLE: begin
                    if (!job_empty) begin
                        job_q   <= job_head;
                        row     <= '0;
                        cand    <= '0;
                        sad_acc <= '0;
                        state   <= ENG_READ;
                    end
                end

                ENG_READ: begin
                    if (row == row_w'(`BM_BLOCK_H - 1)) begin
                        row <= '0;
                        if (cand == cand_t'(`BM_NUM_CAND - 1)) state <= ENG_DRAIN;
                        else cand <= cand + 1'b1;
                    end else begin
                        row <= row + 1'b1;
                    end
                end

                ENG_DRAIN: state <= ENG_EMIT; // Last row is scored here

                ENG_EMIT: begin
                    if ((job_q.index.row == blk_coord_t'(`BM_BLOCKS_PER_COL - 1)) &&
                        (job_q.index.col == blk_coord_t'(`BM_BLOCKS_PER_ROW - 1))) begin
                        done_img <= job_q.index.img + 1'b1;
                    end
                    state <= ENG_IDLE;
                end

                default: state <= ENG_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* bm_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bm_cfg.svh"

module bm_top (
    input  wire                       clk,
    input  wire                       reset,
    input  wire bm_geom_pkg::img_num_t img_number_in,
    input  wire                       load_en,
    input  wire                       load_sel, // High selects the search memory
    input  wire bm_geom_pkg::word_addr_t  load_addr,
    input  wire bm_geom_pkg::pixel_word_t load_data,
    output logic                      bm_idle,
    output logic                      bm_working_buf,
    output logic                      res_valid,
    output bm_job_pkg::bm_result_t    res
);

    import bm_geom_pkg::*;
    import bm_job_pkg::*;

    logic        blk_wr_en;
    logic        srch_wr_en;
    logic        job_push;
    logic        job_space;
    logic        job_pop;
    logic        job_empty;
    bm_job_t     job;
    bm_job_t     job_head;
    word_addr_t  blk_rd_addr;
    word_addr_t  srch_rd_addr;
    pixel_word_t blk_rd_data;
    pixel_word_t srch_rd_data;
    img_num_t    done_img;

    assign blk_wr_en  = load_en && !load_sel;
    assign srch_wr_en = load_en && load_sel;

    bm_frame_ram #(.depth(`BM_THIRD_DEPTH)) u_blk_ram (
        .clk(clk), .wr_en(blk_wr_en), .wr_addr(load_addr), .wr_data(load_data),
        .rd_addr(blk_rd_addr), .rd_data(blk_rd_data)
    );

    bm_frame_ram #(.depth(`BM_CENTER_DEPTH)) u_srch_ram (
        .clk(clk), .wr_en(srch_wr_en), .wr_addr(load_addr), .wr_data(load_data),
        .rd_addr(srch_rd_addr), .rd_data(srch_rd_data)
    );

    bm_ctrl_fsm u_ctrl (
        .clk(clk), .reset(reset), .img_number_in(img_number_in), .job_space(job_space),
        .done_img(done_img), .job_push(job_push), .job(job), .bm_idle(bm_idle),
        .bm_working_buf(bm_working_buf)
    );

    bm_job_fifo u_fifo (
        .clk(clk), .reset(reset), .push(job_push), .push_data(job), .pop(job_pop),
        .head(job_head), .empty(job_empty), .space(job_space)
    );

    bm_sad_engine u_engine (
        .clk(clk), .reset(reset), .job_head(job_head), .job_empty(job_empty),
        .job_pop(job_pop), .blk_rd_addr(blk_rd_addr), .srch_rd_addr(srch_rd_addr),
        .blk_rd_data(blk_rd_data), .srch_rd_data(srch_rd_data), .res_valid(res_valid),
        .res(res), .done_img(done_img)
    );

endmodule

`default_nettype wire

/* tb_bm_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bm_cfg.svh"

module tb_bm_top;

    import bm_geom_pkg::*;
    import bm_job_pkg::*;

    localparam int clk_period     = 4;
    localparam int num_images     = 3;
    localparam int jobs_per_image = `BM_BLOCKS_PER_ROW * `BM_BLOCKS_PER_COL;
    localparam int real_cols      = `BM_THIRD_W / `BM_BLOCK_W;
    localparam int blk_half       = `BM_FRAME_WORDS * `BM_THIRD_H;
    localparam int srch_half      = `BM_CENTER_WORDS * `BM_THIRD_H;
    localparam int win_margin     = (`BM_SEARCH_H - `BM_BLOCK_H) / 2;
    localparam int planted_img    = 1;
    localparam int idle_cycles    = 16;
    // Engine work per job with slack for the pop and the FIFO turnaround
    localparam int job_cycles     = 2 * (`BM_NUM_CAND * `BM_BLOCK_H + 4);
    localparam int load_cycles    = 2 * (`BM_THIRD_DEPTH + `BM_CENTER_DEPTH);
    localparam int timeout_cycles = num_images * (jobs_per_image * job_cycles + idle_cycles + 8)
                                    + load_cycles + 100;

    logic        clk;
    logic        reset;
    img_num_t    img_number_in;
    logic        load_en;
    logic        load_sel;
    word_addr_t  load_addr;
    pixel_word_t load_data;
    logic        bm_idle;
    logic        bm_working_buf;
    logic        res_valid;
    bm_result_t  res;

    pixel_word_t blk_model  [`BM_THIRD_DEPTH];  // What the block memory should hold
    pixel_word_t srch_model [`BM_CENTER_DEPTH];
    bm_result_t  exp_q [$];
    int          results_seen;
    bit          fifo_full_seen;
    int unsigned seed_init;

    bm_top u_bm_top (
        .clk(clk), .reset(reset), .img_number_in(img_number_in), .load_en(load_en),
        .load_sel(load_sel), .load_addr(load_addr), .load_data(load_data),
        .bm_idle(bm_idle), .bm_working_buf(bm_working_buf), .res_valid(res_valid), .res(res)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // A word at or past the depth reads as zero and addresses wrap at 16 bits
    function automatic pixel_word_t model_read(input bit is_srch, input int addr);
        int a;
        a = addr & 16'hffff;
        if (is_srch) return (a < `BM_CENTER_DEPTH) ? srch_model[a] : '0;
        return (a < `BM_THIRD_DEPTH) ? blk_model[a] : '0;
    endfunction

    function automatic bm_result_t expect_block(input int img, input int brow, input int bcol);
        bm_result_t  r;
        int          blk_base;
        int          win_base;
        int          total;
        int          best;
        int          best_k;
        int          d;
        pixel_word_t bw;
        pixel_word_t sw;
        blk_base = (img % 2) * blk_half + brow * `BM_BLOCK_H * `BM_FRAME_WORDS + bcol;
        win_base = (img % 2) * srch_half - win_margin * `BM_CENTER_WORDS  // May go negative
                   + brow * `BM_BLOCK_H * `BM_CENTER_WORDS + bcol;
        best   = 0;
        best_k = 0;
        for (int k = 0; k < `BM_NUM_CAND; k++) begin
            total = 0;
            for (int row = 0; row < `BM_BLOCK_H; row++) begin
                bw = model_read(1'b0, blk_base + row * `BM_FRAME_WORDS);
                sw = model_read(1'b1, win_base + (row + win_margin) * `BM_CENTER_WORDS + k);
                for (int p = 0; p < `BM_PIX_PER_WORD; p++) begin
                    d     = int'(bw[p*8 +: 8]) - int'(sw[p*8 +: 8]);
                    total = total + ((d < 0) ? -d : d);
                end
            end
            if ((k == 0) || (total < best)) begin // A tie keeps the earlier candidate
                best   = total;
                best_k = k;
            end
        end
        r.index.img = img_num_t'(img);
        r.index.row = blk_coord_t'(brow);
        r.index.col = blk_coord_t'(bcol);
        r.best_cand = cand_t'(best_k);
        r.best_sad  = sad_t'(best);
        return r;
    endfunction

    task automatic write_word(input bit is_srch, input int addr, input pixel_word_t data);
        @(posedge clk);
        load_en   <= 1'b1;
        load_sel  <= is_srch;
        load_addr <= word_addr_t'(addr);
        load_data <= data;
        if (is_srch) srch_model[addr] = data;
        else blk_model[addr] = data;
    endtask

    task automatic stop_loading();
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic fill_random(input int half);
        for (int a = 0; a < blk_half; a++) begin
            write_word(1'b0, half * blk_half + a, $urandom);
        end
        for (int a = 0; a < srch_half; a++) begin
            write_word(1'b1, half * srch_half + a, $urandom);
        end
        stop_loading();
    endtask

    // Each real block of the upper half gets an exact copy at candidate col % NUM_CAND
    task automatic plant_copies();
        int blk_a;
        int win_a;
        for (int brow = 0; brow < `BM_BLOCKS_PER_COL; brow++) begin
            for (int bcol = 0; bcol < real_cols; bcol++) begin
                for (int row = 0; row < `BM_BLOCK_H; row++) begin
                    blk_a = blk_half + (brow * `BM_BLOCK_H + row) * `BM_FRAME_WORDS + bcol;
                    win_a = srch_half + (brow * `BM_BLOCK_H + row) * `BM_CENTER_WORDS
                            + bcol + bcol % `BM_NUM_CAND;
                    write_word(1'b1, win_a, blk_model[blk_a]);
                    // Column 0 gets a second copy one word later so two candidates tie
                    if (bcol == 0) write_word(1'b1, win_a + 1, blk_model[blk_a]);
                end
            end
        end
        stop_loading();
    endtask

    task automatic run_image(input int img, input bit reload_lower);
        results_seen = 0;
        for (int brow = 0; brow < `BM_BLOCKS_PER_COL; brow++) begin
            for (int bcol = 0; bcol < `BM_BLOCKS_PER_ROW; bcol++) begin
                exp_q.push_back(expect_block(img, brow, bcol)); // Raster order
            end
        end
        @(posedge clk);
        img_number_in <= img_num_t'(img + 1);
        @(negedge clk);
        while (bm_idle) @(negedge clk);
        assert (bm_working_buf == img[0]) else stop_on_failure($sformatf(
            "[ERROR] %0t: image %0d scans with bm_working_buf=%0b", $time, img, bm_working_buf));
        if (reload_lower) fill_random(0); // The scan only reads the upper halves
        @(negedge clk);
        while (!bm_idle) @(negedge clk);
        assert ((results_seen == jobs_per_image) && (exp_q.size() == 0)) else stop_on_failure(
            $sformatf("[ERROR] %0t: image %0d went idle after %0d of %0d results",
                      $time, img, results_seen, jobs_per_image));
        repeat (idle_cycles) begin
            @(negedge clk);
            assert (bm_idle && !res_valid) else
                stop_on_failure("The controller started work although no new image was requested");
        end
    endtask

    // Result checker
    always @(negedge clk) begin
        bm_result_t want;
        if (!reset && !u_bm_top.job_space) fifo_full_seen = 1'b1;
        if (!reset && res_valid) begin
            if (exp_q.size() == 0) begin
                stop_on_failure("A result arrived while no result was expected");
            end else begin
                want = exp_q.pop_front();
                assert (res == want) else stop_on_failure($sformatf(
                    "[ERROR] %0t: got img %0d r%0d c%0d cand %0d sad %0d, %s %0d r%0d c%0d %0d %0d",
                    $time, res.index.img, res.index.row, res.index.col, res.best_cand,
                    res.best_sad, "expected", want.index.img, want.index.row, want.index.col,
                    want.best_cand, want.best_sad));
                if ((res.index.img == planted_img) && (res.index.col < real_cols)) begin
                    assert ((res.best_sad == 0) && (res.best_cand == res.index.col % `BM_NUM_CAND))
                    else stop_on_failure($sformatf(
                        "[ERROR] %0t: planted block c%0d not found, cand %0d sad %0d",
                        $time, res.index.col, res.best_cand, res.best_sad));
                end
                results_seen++;
            end
        end
    end

    initial begin
        #(timeout_cycles * clk_period);
        stop_on_failure($sformatf("Timeout: the run did not finish in %0d cycles", timeout_cycles));
    end

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        img_number_in  = '0;
        load_en        = 1'b0;
        load_sel       = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        results_seen   = 0;
        fifo_full_seen = 1'b0;
        seed_init      = $urandom(70020);
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!res_valid && bm_idle && !bm_working_buf) else stop_on_failure($sformatf(
            "[ERROR] %0t: after reset res_valid=%0b bm_idle=%0b bm_working_buf=%0b",
            $time, res_valid, bm_idle, bm_working_buf));

        fill_random(0);
        fill_random(1);
        plant_copies();

        run_image(0, 1'b0);
        run_image(1, 1'b1); // Lower halves are rewritten while image 1 runs
        run_image(2, 1'b0);

        if ((exp_q.size() == 0) && fifo_full_seen) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_on_failure("The run ended with results pending or without the FIFO ever filling");
        end
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
bm_geom_pkg.sv
bm_job_pkg.sv
bm_frame_ram.sv
bm_ctrl_fsm.sv
bm_job_fifo.sv
bm_sad_engine.sv
bm_top.sv
tb_bm_top.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
rm -f sim.log && \
verilator --binary --assert -Wno-fatal --top-module tb_bm_top -f build.f -o tb_bm_top \
    || { echo "Build failed"; exit 1; }
./obj_dir/tb_bm_top > sim.log 2>&1
cat sim.log
grep -q '\*\*\* PASSED \*\*\*' sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
